// File: Makefile
# Verilator build and run of the ToT core testbench

all: run

compile:
	verilator --binary --timing --top-module tdc_tb -f list.f -Mdir obj_dir -o tdc_sim

run: compile
	./obj_dir/tdc_sim | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean

// File: bench/tdc_checker.sv
// Hit word and register read checker

`timescale 1ns/1ps
`default_nettype none

module tdc_checker (
    input  wire                             DV_CLK,
    input  wire tdc_data_pkg::sample_word_t samples,
    input  wire                             tot_out,
    input  wire tdc_data_pkg::hit_word_t    hit_word,
    input  wire                             hit_valid,
    input  wire [tdc_cfg_pkg::REG_W-1:0]    reg_rdata,
    input  wire                             exp_push,
    input  wire tdc_data_pkg::hit_word_t    exp_word,
    input  wire                             rd_check,
    input  wire [tdc_cfg_pkg::REG_W-1:0]    rd_expect,
    input  wire                             test_end,
    input  wire [7:0]                       test_no,
    input  wire                             run_end,
    output int                              pending,
    output int                              failed_tests
);

    tdc_data_pkg::hit_word_t          exp_q[$];
    tdc_data_pkg::hit_word_t          want;
    logic                             rd_pend = 1'b0;   // read data due this edge
    logic [tdc_cfg_pkg::REG_W-1:0]    rd_want = '0;
    logic                             tot_want = 1'b0;  // any-one of the last accepted word
    logic                             tot_live = 1'b0;
    int                               test_errors = 0;
    int                               total_errors = 0;
    int                               test_count = 0;
    int                               fails = 0;

    always @(posedge DV_CLK) begin
        if (hit_valid) begin
            if (exp_q.size() == 0) begin
                $display("error at %0d ns: unexpected hit word %h", $time, hit_word);
                test_errors++;
            end else begin
                want = exp_q.pop_front();  // words must arrive in order
                if (hit_word !== want) begin
                    $display("error at %0d ns: hit word %h, expected %h",
                             $time, hit_word, want);
                    test_errors++;
                end
            end
        end
        if (rd_pend && reg_rdata !== rd_want) begin
            $display("error at %0d ns: register read %h, expected %h",
                     $time, reg_rdata, rd_want);
            test_errors++;
        end
        if (tot_live && tot_out !== tot_want) begin
            $display("error at %0d ns: tot_out %b, expected %b", $time, tot_out, tot_want);
            test_errors++;
        end
        if (exp_push) begin
            exp_q.push_back(exp_word);
        end
        if (test_end) begin
            if (test_errors == 0) begin
                $display("test %0d: ok", test_no);
            end else begin
                $display("test %0d: %0d mismatches", test_no, test_errors);
                fails++;
            end
            total_errors += test_errors;
            test_errors = 0;
            test_count++;
        end
        if (run_end) begin
            if (test_errors != 0) begin
                $display("after the last test: %0d mismatches", test_errors);
                fails++;
                total_errors += test_errors;
                test_errors = 0;
            end
            $display("tests run %0d, failing %0d, mismatches %0d",
                     test_count, fails, total_errors);
        end
        rd_pend      <= rd_check;  // rdata is registered one cycle after the read
        rd_want      <= rd_expect;
        tot_want     <= |samples;  // word registered at this edge
        tot_live     <= 1'b1;
        pending      <= exp_q.size();
        failed_tests <= fails;
    end

endmodule

`default_nettype wire

// File: bench/tdc_tb.sv
// ToT core testbench

`timescale 1ns/1ps
`default_nettype none

module tdc_tb;

    localparam int MAX_CMDS   = 128;
    localparam int WAIT_LIMIT = 500;  // cycles per end-of-test wait

    logic                              DV_CLK = 1'b0;
    logic                              RST_SYNC = 1'b1;
    tdc_data_pkg::sample_word_t        samples = '0;
    logic                              ext_en = 1'b0;
    logic                              arm = 1'b0;
    logic [tdc_data_pkg::TAG_W-1:0]    timestamp = '0;
    logic [tdc_cfg_pkg::ADDR_W-1:0]    reg_addr = '0;
    logic [tdc_cfg_pkg::REG_W-1:0]     reg_wdata = '0;
    logic                              reg_write = 1'b0;
    logic                              reg_read = 1'b0;
    logic                              hit_credit = 1'b0;
    tdc_data_pkg::hit_word_t           hit_word;
    logic                              hit_valid;
    logic [tdc_cfg_pkg::REG_W-1:0]     reg_rdata;
    logic                              tot_out;

    logic                              exp_push = 1'b0;
    tdc_data_pkg::hit_word_t           exp_word = '0;
    logic                              rd_check = 1'b0;
    logic [tdc_cfg_pkg::REG_W-1:0]     rd_expect = '0;
    logic                              test_end = 1'b0;
    logic [7:0]                        test_no = '0;
    logic                              run_end = 1'b0;
    int                                pending;
    int                                failed_tests;

    logic [35:0]                       cmds [MAX_CMDS];  // op nibble, 32-bit argument
    int                                cmd_idx = 0;
    logic [3:0]                        op;
    logic [31:0]                       arg;
    logic                              run_done = 1'b0;
    logic                              aborted = 1'b0;
    logic                              timed_out = 1'b0;

    logic                              hold = 1'b0;     // consumer withholds credits
    int                                owed = 0;        // words seen, credits not yet back
    int                                credit_wait = 0;
    logic [31:0]                       lcg_state = 32'd62461;

    tdc_core tdc_core_i (
        .DV_CLK     (DV_CLK),
        .RST_SYNC   (RST_SYNC),
        .samples    (samples),
        .ext_en     (ext_en),
        .arm        (arm),
        .timestamp  (timestamp),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_write  (reg_write),
        .reg_read   (reg_read),
        .hit_credit (hit_credit),
        .hit_word   (hit_word),
        .hit_valid  (hit_valid),
        .reg_rdata  (reg_rdata),
        .tot_out    (tot_out)
    );

    tdc_checker tdc_checker_i (
        .DV_CLK       (DV_CLK),
        .samples      (samples),
        .tot_out      (tot_out),
        .hit_word     (hit_word),
        .hit_valid    (hit_valid),
        .reg_rdata    (reg_rdata),
        .exp_push     (exp_push),
        .exp_word     (exp_word),
        .rd_check     (rd_check),
        .rd_expect    (rd_expect),
        .test_end     (test_end),
        .test_no      (test_no),
        .run_end      (run_end),
        .pending      (pending),
        .failed_tests (failed_tests)
    );

    always #20 DV_CLK = ~DV_CLK;

    function automatic int next_delay();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[17:16]);  // 0 to 3 cycles
    endfunction

    // consumer returns one credit per received word
    always @(posedge DV_CLK) begin
        if (RST_SYNC) begin
            owed        <= 0;
            credit_wait <= 0;
            hit_credit  <= 1'b0;
        end else if (credit_wait != 0) begin
            credit_wait <= credit_wait - 1;
            hit_credit  <= 1'b0;
            owed        <= owed + int'(hit_valid);
        end else if (owed != 0 && !hold) begin
            hit_credit  <= 1'b1;
            owed        <= owed - 1 + int'(hit_valid);
            credit_wait <= next_delay();
        end else begin
            hit_credit  <= 1'b0;
            owed        <= owed + int'(hit_valid);
        end
    end

    task automatic next_edge();
        @(posedge DV_CLK);
        arm       <= 1'b0;  // strobes last one cycle
        reg_write <= 1'b0;
        reg_read  <= 1'b0;
        exp_push  <= 1'b0;
        rd_check  <= 1'b0;
        test_end  <= 1'b0;
        run_end   <= 1'b0;
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [7:0] data);
        next_edge();
        reg_write <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
    endtask

    task automatic read_check(input logic [3:0] addr, input logic [7:0] want);
        next_edge();
        reg_read  <= 1'b1;
        reg_addr  <= addr;
        rd_check  <= 1'b1;
        rd_expect <= want;
    endtask

    task automatic drive_samples(input logic [15:0] word, input logic [15:0] count);
        for (int n = 0; n < int'(count); n++) begin
            next_edge();
            samples <= word;
        end
    endtask

    task automatic push_expected(input logic [31:0] word);
        next_edge();
        exp_push <= 1'b1;
        exp_word <= word;
    endtask

    task automatic pulse_arm();
        next_edge();
        arm <= 1'b1;
    endtask

    task automatic set_hold(input logic value);
        next_edge();
        hold <= value;
    endtask

    // soft reset, then timestamp and mode byte
    task automatic begin_test(input logic [31:0] cfg);
        write_reg(tdc_cfg_pkg::ADDR_CTRL, 8'h00);
        next_edge();
        next_edge();
        test_no   <= cfg[31:24];
        timestamp <= cfg[15:0];
        write_reg(tdc_cfg_pkg::ADDR_MODE, cfg[23:16]);
    endtask

    task automatic wait_test_done();
        int cycles;
        cycles = 0;
        next_edge();
        while ((pending != 0 || owed != 0 || hold) && !timed_out) begin
            if (cycles == WAIT_LIMIT) begin
                $display("timeout: test %0d still waits for hit words or credits", test_no);
                timed_out = 1'b1;
            end else begin
                next_edge();
                cycles++;
            end
        end
        if (!timed_out) begin
            test_end <= 1'b1;
        end
    endtask

    initial begin
        $readmemh("bench/tdc_tests.txt", cmds);
        repeat (3) @(posedge DV_CLK);
        RST_SYNC <= 1'b0;
        while (!run_done && !aborted && !timed_out && cmd_idx < MAX_CMDS) begin
            op  = cmds[cmd_idx][35:32];
            arg = cmds[cmd_idx][31:0];
            case (op)
                4'h1: begin_test(arg);
                4'h2: write_reg(arg[11:8], arg[7:0]);
                4'h3: drive_samples(arg[15:0], arg[31:16]);
                4'h4: push_expected(arg);
                4'h5: read_check(arg[11:8], arg[7:0]);
                4'h6: pulse_arm();
                4'h7: set_hold(arg[0]);
                4'h8: wait_test_done();
                4'hf: run_done = 1'b1;
                default: begin
                    $display("bad command %h in the test file", cmds[cmd_idx]);
                    aborted = 1'b1;
                end
            endcase
            cmd_idx++;
        end
        if (!run_done && !aborted && !timed_out) begin
            $display("test file ended without an end-of-run command");
        end
        if (run_done) begin
            next_edge();
            run_end <= 1'b1;
            next_edge();
            next_edge();
        end
        if (run_done && failed_tests == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/tdc_tests.txt
// each value is an op digit and a 32-bit argument: 1 test/mode/timestamp, 2 write addr/data,
// 3 count/samples, 4 expected hit word, 5 read addr/expected, 6 arm, 7 hold, 8 end, f finish
101010000 44000002E 440001002
3000100FF 30002FFFF 30001FC00 300010001 300018000 300060000 800000000
10209BEEF 44BEEF008 44BEEF006
300010FF0 300020000 300010003 30001F000 300060000 800000000
103010000 440000000 440001FFF
300010001 30100FFFF 300010000 300017FFF 300FFFFFF 300060000 800000000
104050000 440000002
300010001 300018000 300040000 600000000 300020000
300010001 300018000 300040000 300010001 300018000 300060000 800000000
105010000 700000001
440000004 440001004 440002004 440003004 440004004 440005004 440006004 440007004
3000A00F0 300040000 50000020A 500000602 700000000 800000000
1060A0000 500000001 50000010A 200000101
440000004 440001004 440002004 3000300F0 300100000
500000203 500000300 500000400 500000500 500000600 500000700
200000000 300030000 500000200 800000000
f00000000

// File: list.f
source/tdc_cfg_pkg.sv
source/tdc_data_pkg.sv
source/tot_sampler.sv
source/tot_measure.sv
source/tdc_regs.sv
source/credit_fifo.sv
source/tdc_core.sv
bench/tdc_checker.sv
bench/tdc_tb.sv

// File: source/credit_fifo.sv
// Hit-word FIFO with credit flow control

`timescale 1ns/1ps
`default_nettype none

module credit_fifo (
    input  wire                                DV_CLK,
    input  wire                                RST_SYNC,
    input  wire                                soft_rst,
    input  wire                                wr,
    input  wire tdc_data_pkg::hit_word_t       wr_word,
    input  wire                                hit_credit,
    output logic                               hit_valid,
    output tdc_data_pkg::hit_word_t            hit_word,
    output logic [tdc_cfg_pkg::LOST_W-1:0]     lost_cnt
);

    tdc_data_pkg::hit_word_t mem [tdc_cfg_pkg::FIFO_DEPTH];

    logic                             rst;
    logic [tdc_cfg_pkg::FIFO_PTR_W-1:0] wr_ptr, rd_ptr;
    logic [tdc_cfg_pkg::FIFO_PTR_W:0]   count;
    logic [tdc_cfg_pkg::CREDIT_W-1:0]   credits;
    logic                             pop;
    logic                             push;
    logic                             full;

    assign rst  = RST_SYNC || soft_rst;
    assign pop  = (count != '0) && (credits != '0);
    assign full = (count == (tdc_cfg_pkg::FIFO_PTR_W + 1)'(tdc_cfg_pkg::FIFO_DEPTH)) && !pop;
    assign push = wr && !full;

    always_ff @(posedge DV_CLK) begin
        if (push) begin
            mem[wr_ptr] <= wr_word;
        end
        if (pop) begin
            hit_word <= mem[rd_ptr];  // output register
        end
    end

    always_ff @(posedge DV_CLK) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            credits   <= tdc_cfg_pkg::CREDIT_W'(tdc_cfg_pkg::CREDITS_INIT);
            hit_valid <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count     <= count + push - pop;
            credits   <= credits - pop + hit_credit;  // one credit per word sent
            hit_valid <= pop;
        end
    end

    always_ff @(posedge DV_CLK) begin
        if (rst) begin
            lost_cnt <= '0;
        end else if (wr && full && lost_cnt != '1) begin
            lost_cnt <= lost_cnt + 1'b1;  // saturates at 255
        end
    end

endmodule

`default_nettype wire

// File: source/tdc_cfg_pkg.sv
// ToT core configuration constants

package tdc_cfg_pkg;

    localparam int ADDR_W = 4;    // register bus address width
    localparam int REG_W  = 8;    // register bus data width

    localparam logic [ADDR_W-1:0] ADDR_CTRL = 4'd0;  // write pulses soft reset, reads version
    localparam logic [ADDR_W-1:0] ADDR_MODE = 4'd1;
    localparam logic [ADDR_W-1:0] ADDR_EVT0 = 4'd2;  // read takes the snapshot
    localparam logic [ADDR_W-1:0] ADDR_EVT1 = 4'd3;
    localparam logic [ADDR_W-1:0] ADDR_EVT2 = 4'd4;
    localparam logic [ADDR_W-1:0] ADDR_EVT3 = 4'd5;
    localparam logic [ADDR_W-1:0] ADDR_LOST = 4'd6;

    // bit positions inside the mode register
    localparam int MODE_EN_BIT       = 0;
    localparam int MODE_EN_EXT_BIT   = 1;
    localparam int MODE_ARM_BIT      = 2;
    localparam int MODE_WRITE_TS_BIT = 3;

    localparam logic [REG_W-1:0] VERSION = 8'd1;

    localparam int EVT_W  = 32;   // event counter
    localparam int LOST_W = 8;    // lost-word counter, saturating

    localparam int CREDITS_INIT = 4;                          // consumer buffer depth
    localparam int CREDIT_W     = $clog2(CREDITS_INIT + 1);
    localparam int FIFO_DEPTH   = 4;
    localparam int FIFO_PTR_W   = $clog2(FIFO_DEPTH);

    typedef struct packed {
        logic write_ts;  // tag carries timestamp
        logic arm_mode;  // measure only after arm
        logic en_ext;    // ext_en also enables
        logic en;
    } tdc_mode_t;

endpackage

// File: source/tdc_core.sv
// ToT measurement core top level

`timescale 1ns/1ps
`default_nettype none

module tdc_core (
    input  wire                                DV_CLK,
    input  wire                                RST_SYNC,
    input  wire tdc_data_pkg::sample_word_t    samples,
    input  wire                                ext_en,
    input  wire                                arm,
    input  wire [tdc_data_pkg::TAG_W-1:0]      timestamp,
    input  wire [tdc_cfg_pkg::ADDR_W-1:0]      reg_addr,
    input  wire [tdc_cfg_pkg::REG_W-1:0]       reg_wdata,
    input  wire                                reg_write,
    input  wire                                reg_read,
    input  wire                                hit_credit,
    output tdc_data_pkg::hit_word_t            hit_word,
    output logic                               hit_valid,
    output logic [tdc_cfg_pkg::REG_W-1:0]      reg_rdata,
    output logic                               tot_out
);

    tdc_data_pkg::sample_flags_t       flags;
    tdc_cfg_pkg::tdc_mode_t            mode;
    tdc_data_pkg::hit_word_t           wr_word;
    logic                              wr;
    logic                              soft_rst;
    logic [tdc_cfg_pkg::EVT_W-1:0]     event_cnt;
    logic [tdc_cfg_pkg::LOST_W-1:0]    lost_cnt;

    tot_sampler tot_sampler_i (
        .DV_CLK   (DV_CLK),
        .RST_SYNC (RST_SYNC),
        .samples  (samples),
        .flags    (flags),
        .tot_out  (tot_out)
    );

    tot_measure tot_measure_i (
        .DV_CLK    (DV_CLK),
        .RST_SYNC  (RST_SYNC),
        .soft_rst  (soft_rst),
        .flags     (flags),
        .mode      (mode),
        .ext_en    (ext_en),
        .arm       (arm),
        .timestamp (timestamp),
        .wr        (wr),
        .wr_word   (wr_word),
        .event_cnt (event_cnt)
    );

    tdc_regs tdc_regs_i (
        .DV_CLK    (DV_CLK),
        .RST_SYNC  (RST_SYNC),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_write (reg_write),
        .reg_read  (reg_read),
        .reg_rdata (reg_rdata),
        .soft_rst  (soft_rst),
        .mode      (mode),
        .event_cnt (event_cnt),
        .lost_cnt  (lost_cnt)
    );

    credit_fifo credit_fifo_i (
        .DV_CLK     (DV_CLK),
        .RST_SYNC   (RST_SYNC),
        .soft_rst   (soft_rst),
        .wr         (wr),
        .wr_word    (wr_word),
        .hit_credit (hit_credit),
        .hit_valid  (hit_valid),
        .hit_word   (hit_word),
        .lost_cnt   (lost_cnt)
    );

endmodule

`default_nettype wire

// File: source/tdc_data_pkg.sv
// ToT measurement data types

package tdc_data_pkg;

    localparam int SAMPLES = 16;                    // samples per DV_CLK
    localparam int ONES_W  = $clog2(SAMPLES + 1);  // popcount width
    localparam int ID_W    = 4;
    localparam int TAG_W   = 16;
    localparam int TOT_W   = 12;

    // bit 15 is the oldest sample, bit 0 the newest
    typedef logic [SAMPLES-1:0] sample_word_t;

    typedef logic [TOT_W-1:0] tot_t;

    localparam logic [ID_W-1:0] DATA_ID = 4'b0100;

    typedef struct packed {
        logic [ID_W-1:0]  ident;
        logic [TAG_W-1:0] tag;   // event count or timestamp
        tot_t             tot;
    } hit_word_t;

    typedef struct packed {
        logic [ONES_W-1:0] ones;
        logic              any_one;
        logic              any_zero;
        logic              short_pulse;  // ones present, newest sample low
    } sample_flags_t;

endpackage

// File: source/tdc_regs.sv
// Control and status register bank

`timescale 1ns/1ps
`default_nettype none

module tdc_regs (
    input  wire                                DV_CLK,
    input  wire                                RST_SYNC,
    input  wire [tdc_cfg_pkg::ADDR_W-1:0]      reg_addr,
    input  wire [tdc_cfg_pkg::REG_W-1:0]       reg_wdata,
    input  wire                                reg_write,
    input  wire                                reg_read,
    output logic [tdc_cfg_pkg::REG_W-1:0]      reg_rdata,
    output logic                               soft_rst,
    output tdc_cfg_pkg::tdc_mode_t             mode,
    input  wire [tdc_cfg_pkg::EVT_W-1:0]       event_cnt,
    input  wire [tdc_cfg_pkg::LOST_W-1:0]      lost_cnt
);

    logic                             rst;
    logic                             snap;
    logic [tdc_cfg_pkg::EVT_W-1:8]    evt_snap;
    logic [tdc_cfg_pkg::LOST_W-1:0]   lost_snap;
    logic [tdc_cfg_pkg::REG_W-1:0]    mode_byte;

    assign rst  = RST_SYNC || soft_rst;
    assign snap = reg_read && (reg_addr == tdc_cfg_pkg::ADDR_EVT0);

    always_ff @(posedge DV_CLK) begin
        if (RST_SYNC) begin
            soft_rst <= 1'b0;
        end else begin
            soft_rst <= reg_write && (reg_addr == tdc_cfg_pkg::ADDR_CTRL);
        end
    end

    always_ff @(posedge DV_CLK) begin
        if (rst) begin
            mode <= '0;
        end else if (reg_write && reg_addr == tdc_cfg_pkg::ADDR_MODE) begin
            mode.en       <= reg_wdata[tdc_cfg_pkg::MODE_EN_BIT];
            mode.en_ext   <= reg_wdata[tdc_cfg_pkg::MODE_EN_EXT_BIT];
            mode.arm_mode <= reg_wdata[tdc_cfg_pkg::MODE_ARM_BIT];
            mode.write_ts <= reg_wdata[tdc_cfg_pkg::MODE_WRITE_TS_BIT];
        end
    end

    // byte 0 read freezes all counter bytes
    always_ff @(posedge DV_CLK) begin
        if (rst) begin
            evt_snap  <= '0;
            lost_snap <= '0;
        end else if (snap) begin
            evt_snap  <= event_cnt[tdc_cfg_pkg::EVT_W-1:8];
            lost_snap <= lost_cnt;
        end
    end

    always_comb begin
        mode_byte = '0;
        mode_byte[tdc_cfg_pkg::MODE_EN_BIT]       = mode.en;
        mode_byte[tdc_cfg_pkg::MODE_EN_EXT_BIT]   = mode.en_ext;
        mode_byte[tdc_cfg_pkg::MODE_ARM_BIT]      = mode.arm_mode;
        mode_byte[tdc_cfg_pkg::MODE_WRITE_TS_BIT] = mode.write_ts;
    end

    always_ff @(posedge DV_CLK) begin
        if (RST_SYNC) begin
            reg_rdata <= '0;
        end else if (reg_read) begin
            case (reg_addr)
                tdc_cfg_pkg::ADDR_CTRL: reg_rdata <= tdc_cfg_pkg::VERSION;
                tdc_cfg_pkg::ADDR_MODE: reg_rdata <= mode_byte;
                tdc_cfg_pkg::ADDR_EVT0: reg_rdata <= event_cnt[7:0];  // live, matches snapshot
                tdc_cfg_pkg::ADDR_EVT1: reg_rdata <= evt_snap[15:8];
                tdc_cfg_pkg::ADDR_EVT2: reg_rdata <= evt_snap[23:16];
                tdc_cfg_pkg::ADDR_EVT3: reg_rdata <= evt_snap[31:24];
                tdc_cfg_pkg::ADDR_LOST: reg_rdata <= lost_snap;
                default:                reg_rdata <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/tot_measure.sv
// ToT measurement state machine

`timescale 1ns/1ps
`default_nettype none

module tot_measure (
    input  wire                              DV_CLK,
    input  wire                              RST_SYNC,
    input  wire                              soft_rst,
    input  wire tdc_data_pkg::sample_flags_t flags,
    input  wire tdc_cfg_pkg::tdc_mode_t      mode,
    input  wire                              ext_en,
    input  wire                              arm,
    input  wire [tdc_data_pkg::TAG_W-1:0]    timestamp,
    output logic                             wr,
    output tdc_data_pkg::hit_word_t          wr_word,
    output logic [tdc_cfg_pkg::EVT_W-1:0]    event_cnt
);

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        ARMED = 2'd1,
        COUNT = 2'd2
    } state_t;

    state_t state, next_state;

    logic                           rst;
    logic                           enabled;
    logic                           short_fin;  // short pulse finishes at once
    logic                           start;
    logic [tdc_data_pkg::TOT_W:0]   sum;        // extra bit catches overflow
    tdc_data_pkg::tot_t             acc_q;
    logic                           ovf_q;
    logic [tdc_data_pkg::TAG_W-1:0] ts_q;
    tdc_data_pkg::tot_t             tot_val;

    assign rst     = RST_SYNC || soft_rst;
    assign enabled = mode.en || (mode.en_ext && ext_en);

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (flags.any_one && enabled && !mode.arm_mode && !flags.short_pulse) begin
                    next_state = COUNT;
                end else if (arm && enabled && mode.arm_mode) begin
                    next_state = ARMED;
                end
            end
            ARMED: begin
                if (flags.any_one && !flags.short_pulse) begin
                    next_state = COUNT;
                end else if (!enabled || flags.short_pulse) begin
                    next_state = IDLE;
                end
            end
            COUNT: begin
                if (flags.any_zero || !enabled) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge DV_CLK) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    assign short_fin = flags.short_pulse && enabled &&
                       ((state == IDLE && !mode.arm_mode) || state == ARMED);
    assign start     = (state != COUNT) && (next_state == COUNT);
    assign wr        = short_fin || (state == COUNT && next_state == IDLE);

    assign sum = {1'b0, acc_q} + (tdc_data_pkg::TOT_W + 1)'(flags.ones);

    // running sum from the start word on
    always_ff @(posedge DV_CLK) begin
        if (rst) begin
            acc_q <= '0;
            ovf_q <= 1'b0;
            ts_q  <= '0;
        end else if (start) begin
            acc_q <= tdc_data_pkg::TOT_W'(flags.ones);
            ovf_q <= 1'b0;
            ts_q  <= timestamp;
        end else if (state == COUNT) begin
            if (sum[tdc_data_pkg::TOT_W]) begin
                ovf_q <= 1'b1;  // sticky, result will read 0
            end else begin
                acc_q <= sum[tdc_data_pkg::TOT_W-1:0];
            end
        end
    end

    always_comb begin
        if (short_fin) begin
            tot_val = tdc_data_pkg::TOT_W'(flags.ones);
        end else if (ovf_q || sum[tdc_data_pkg::TOT_W]) begin
            tot_val = '0;  // overflow bin
        end else begin
            tot_val = sum[tdc_data_pkg::TOT_W-1:0];
        end
    end

    always_comb begin
        wr_word.ident = tdc_data_pkg::DATA_ID;
        if (mode.write_ts) begin
            wr_word.tag = short_fin ? timestamp : ts_q;  // short pulse stamps at finish
        end else begin
            wr_word.tag = event_cnt[tdc_data_pkg::TAG_W-1:0];
        end
        wr_word.tot = tot_val;
    end

    always_ff @(posedge DV_CLK) begin
        if (rst) begin
            event_cnt <= '0;
        end else if (wr) begin
            event_cnt <= event_cnt + 1'b1;  // counts dropped words too
        end
    end

endmodule

`default_nettype wire

// File: source/tot_sampler.sv
// Sample word register and hit flags

`timescale 1ns/1ps
`default_nettype none

module tot_sampler (
    input  wire                          DV_CLK,
    input  wire                          RST_SYNC,
    input  wire tdc_data_pkg::sample_word_t samples,
    output tdc_data_pkg::sample_flags_t  flags,
    output logic                         tot_out
);

    tdc_data_pkg::sample_word_t word_q;

    always_ff @(posedge DV_CLK) begin
        if (RST_SYNC) begin
            word_q <= '0;
        end else begin
            word_q <= samples;
        end
    end

    always_comb begin
        logic [tdc_data_pkg::ONES_W-1:0] cnt;
        cnt = '0;
        for (int i = 0; i < tdc_data_pkg::SAMPLES; i++) begin
            cnt = cnt + tdc_data_pkg::ONES_W'(word_q[i]);
        end
        flags.ones        = cnt;
        flags.any_one     = |word_q;
        flags.any_zero    = ~&word_q;
        flags.short_pulse = (|word_q) && !word_q[0];  // pulse ended inside this word
    end

    assign tot_out = flags.any_one;  // discriminator copy

endmodule

`default_nettype wire
